//--- hdl/fir_defines.svh
// FIR filter configuration
// widths, tap counts and pipeline depths shared by the datapath and the testbench

`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// sample, coefficient and partial sum width
`define FIR_DATA_W 18

// filter length and unique coefficients after the symmetric fold
`define FIR_NUM_TAPS 28
`define FIR_NUM_UNIQ 14

// registered adder levels after the multiply
`define FIR_TREE_LEVELS 4

// taps plus fold, multiply and tree registers
`define FIR_VALID_DEPTH (`FIR_NUM_TAPS + 2 + `FIR_TREE_LEVELS)

`endif

//--- hdl/fir_pkg.sv
// FIR filter package
// sample and coefficient types, and the symmetric coefficient table

`default_nettype none

`include "fir_defines.svh"

package fir_pkg;

	// signed sample, also used for every wrapped partial sum
	typedef logic signed [`FIR_DATA_W-1:0] sample_t;

	// signed constant coefficient
	typedef logic signed [`FIR_DATA_W-1:0] coeff_t;

	// first half of the impulse response, c[k] == c[27-k]
	localparam coeff_t FIR_COEFFS [`FIR_NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0
	};

endpackage

`default_nettype wire

//--- hdl/fir_tap_delay_line.sv
// FIR tap delay line
// 28-stage sample shift register, cleared by reset and advanced on the clock enable

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_tap_delay_line
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     i_clk_ena,
	input  sample_t i_in,
	output sample_t o_taps [`FIR_NUM_TAPS]
);

	// ************************************************************
	// sample shift register
	// ************************************************************

	// tap 0 takes the new sample, tap j the one from j edges back
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
				o_taps[j] <= '0;
			end
		end else if (i_clk_ena) begin
			o_taps[0] <= i_in;
			for (int j = 1; j < `FIR_NUM_TAPS; j++) begin
				o_taps[j] <= o_taps[j-1];
			end
		end
	end

	// ************************************************************
	// checks
	// ************************************************************

	// a stalled edge leaves the whole window untouched
	for (genvar j = 0; j < `FIR_NUM_TAPS; j++) begin : g_hold_chk
		a_tap_hold : assert property (
			@(posedge clk) disable iff (reset)
			!i_clk_ena |=> $stable(o_taps[j])
		);
	end

endmodule

`default_nettype wire

//--- hdl/fir_fold_multiply.sv
// FIR fold and multiply stage
// pre-adds symmetric tap pairs, then scales each pair sum by its constant coefficient

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_fold_multiply
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     i_clk_ena,
	input  sample_t i_taps [`FIR_NUM_TAPS],
	output sample_t o_products [`FIR_NUM_UNIQ]
);

	// pair sums, tap k plus tap 27-k
	sample_t fold_q [`FIR_NUM_UNIQ];

	// ************************************************************
	// symmetric pre-add
	// ************************************************************

	// sum wraps to 18 bits
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
				fold_q[k] <= i_taps[k] + i_taps[`FIR_NUM_TAPS-1-k];
			end
		end
	end

	// ************************************************************
	// coefficient multiply
	// ************************************************************

	// only the low 18 bits of each product are kept
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
				o_products[k] <= fold_q[k] * FIR_COEFFS[k];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fir_adder_tree.sv
// FIR adder tree
// four registered levels reduce the 14 products to one wrapped output sample

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_adder_tree
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     i_clk_ena,
	input  sample_t i_products [`FIR_NUM_UNIQ],
	output sample_t o_sum
);

	localparam int L1_N = `FIR_NUM_UNIQ / 2;
	localparam int L2_N = (L1_N + 1) / 2;
	localparam int L3_N = L2_N / 2;

	sample_t lvl1_q [L1_N];
	sample_t lvl2_q [L2_N];
	sample_t lvl3_q [L3_N];

	// ************************************************************
	// level 1, pairs of products
	// ************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < L1_N; i++) begin
				lvl1_q[i] <= i_products[2*i] + i_products[2*i+1];
			end
		end
	end

	// ************************************************************
	// level 2, odd sum out passes through a register
	// ************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < L2_N - 1; i++) begin
				lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
			end
			// keeps the last partial sum aligned with the others
			lvl2_q[L2_N-1] <= lvl1_q[L1_N-1];
		end
	end

	// ************************************************************
	// levels 3 and 4
	// ************************************************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int i = 0; i < L3_N; i++) begin
				lvl3_q[i] <= lvl2_q[2*i] + lvl2_q[2*i+1];
			end
		end
	end

	// final wrapped sum
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			o_sum <= lvl3_q[0] + lvl3_q[1];
		end
	end

endmodule

`default_nettype wire

//--- hdl/fir_valid_delay.sv
// FIR valid delay
// shift register that lines up the input valid flag with the datapath latency

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_valid_delay
	import fir_pkg::*;
(
	input  wire  clk,
	input  wire  reset,
	input  wire  i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	logic [`FIR_VALID_DEPTH-1:0] valid_q;

	// one stage per enabled edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[`FIR_VALID_DEPTH-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[`FIR_VALID_DEPTH-1];

	// last stage is fed from the one before it
	a_valid_shift : assert property (
		@(posedge clk) disable iff (reset)
		i_clk_ena |=> o_valid == $past(valid_q[`FIR_VALID_DEPTH-2])
	);

endmodule

`default_nettype wire

//--- hdl/fir_top.sv
// 28-tap symmetric FIR filter
// tap delay line, fold and multiply, adder tree and valid alignment

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_top
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     i_clk_ena,
	input  logic    i_valid,
	input  sample_t i_in,
	output logic    o_valid,
	output sample_t o_out
);

	sample_t taps     [`FIR_NUM_TAPS];
	sample_t products [`FIR_NUM_UNIQ];

	// ************************************************************
	// datapath
	// ************************************************************

	fir_tap_delay_line tap_delay_line_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	// 2 edges from taps to products
	fir_fold_multiply fold_multiply_inst (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	fir_adder_tree adder_tree_inst (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	// ************************************************************
	// valid alignment
	// ************************************************************

	fir_valid_delay valid_delay_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

//--- testbench/fir_tb_clock.sv
// FIR testbench clock and reset
// 40 ns clock, reset held high for the first 5 cycles

`timescale 1ns/1ns
`default_nettype none

module fir_tb_clock (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (5) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/fir_tb.sv
// FIR filter testbench
// window model built from the coefficient table and checked by concurrent assertions

`timescale 1ns/1ns
`default_nettype none

`include "fir_defines.svh"

module fir_tb
	import fir_pkg::*;
();

	localparam int DEPTH = `FIR_VALID_DEPTH;
	// fold, multiply and tree registers between taps and output
	localparam int FRONT = 2 + `FIR_TREE_LEVELS;

	wire     clk;
	wire     reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	integer  seed;
	string   test_name;
	int      err_count;
	int      err_at_start;
	int      pass_count;
	int      fail_count;
	logic    imp_armed;

	// model state
	sample_t x_hist [$];
	logic    v_hist [$];
	int      ena_edges;
	int      imp_age;
	sample_t exp_out;
	logic    exp_valid;
	sample_t imp_exp;
	logic    imp_track;

	fir_tb_clock clock_inst (
		.o_clk   (clk),
		.o_reset (reset)
	);

	fir_top fir_top_inst (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	// ************************************************************
	// reference model
	// ************************************************************

	// sum over the folded window reduced mod 2^18
	function automatic sample_t window_sum();
		longint acc;
		acc = 0;
		for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
			acc += longint'(FIR_COEFFS[k]) * (longint'(x_hist[FRONT + k]) +
				longint'(x_hist[FRONT + `FIR_NUM_TAPS - 1 - k]));
		end
		return sample_t'(acc[`FIR_DATA_W-1:0]);
	endfunction

	// impulse response runs c0..c13 then c13..c0
	function automatic sample_t impulse_value(int age);
		int k;
		k = age - FRONT;
		if (k < 0 || k >= `FIR_NUM_TAPS) begin
			return '0;
		end
		return (k < `FIR_NUM_UNIQ) ? FIR_COEFFS[k] : FIR_COEFFS[`FIR_NUM_TAPS - 1 - k];
	endfunction

	// history indexed by enabled edges with the newest sample at index 0
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			x_hist.delete();
			v_hist.delete();
			for (int i = 0; i < DEPTH; i++) begin
				x_hist.push_back('0);
				v_hist.push_back(1'b0);
			end
			imp_age = 63;
			ena_edges <= 0;
			exp_out   <= '0;
			exp_valid <= 1'b0;
			imp_exp   <= '0;
			imp_track <= 1'b0;
		end else if (i_clk_ena) begin
			x_hist.push_front(i_in);
			void'(x_hist.pop_back());
			v_hist.push_front(i_valid);
			void'(v_hist.pop_back());
			if (imp_armed) begin
				imp_age = 0;
			end else if (imp_age < 63) begin
				imp_age++;
			end
			ena_edges <= ena_edges + 1;
			exp_out   <= window_sum();
			exp_valid <= v_hist[DEPTH-1];
			imp_exp   <= impulse_value(imp_age);
			imp_track <= (imp_age <= 40);
		end
	end

	// ************************************************************
	// checks
	// ************************************************************

	a_out_model : assert property (
		@(posedge clk) disable iff (reset) o_valid |-> o_out == exp_out
	) else begin
		err_count++;
		$display("ERROR %s: o_out expected %0d, actual %0d",
			test_name, $sampled(exp_out), $sampled(o_out));
	end

	a_valid_model : assert property (
		@(posedge clk) disable iff (reset) o_valid == exp_valid
	) else begin
		err_count++;
		$display("ERROR %s: o_valid expected %0b, actual %0b",
			test_name, $sampled(exp_valid), $sampled(o_valid));
	end

	// nothing can be valid before the window has filled
	a_valid_low_after_reset : assert property (
		@(posedge clk) disable iff (reset) (ena_edges < DEPTH) |-> !o_valid
	) else begin
		err_count++;
		$display("%s: o_valid rose only %0d enabled edges after reset",
			test_name, $sampled(ena_edges));
	end

	a_impulse : assert property (
		@(posedge clk) disable iff (reset) imp_track |-> o_out == imp_exp
	) else begin
		err_count++;
		$display("ERROR %s: impulse sample expected %0d, actual %0d",
			test_name, $sampled(imp_exp), $sampled(o_out));
	end

	a_hold_on_stall : assert property (
		@(posedge clk) disable iff (reset)
		(!i_clk_ena && ena_edges >= DEPTH) |=> ($stable(o_out) && $stable(o_valid))
	) else begin
		err_count++;
		$display("%s: output changed across a stalled clock edge", test_name);
	end

	// ************************************************************
	// stimulus helpers
	// ************************************************************

	task automatic apply_inputs(input logic ena, input logic valid, input sample_t data);
		@(posedge clk);
		i_clk_ena <= ena;
		i_valid   <= valid;
		i_in      <= data;
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (reset) begin
			err_count++;
			$display("reset was never released");
		end
	endtask

	task automatic wait_valid_level(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (o_valid !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (o_valid !== level) begin
			err_count++;
			$display("%s: timed out waiting for o_valid to become %0b", test_name, level);
		end
	endtask

	task automatic wait_impulse_done();
		int cycles;
		cycles = 0;
		// the model restarts imp_age on the arming edge
		@(negedge clk);
		while (imp_age <= 40 && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (imp_age <= 40) begin
			err_count++;
			$display("%s: timed out waiting for the impulse to leave the window", test_name);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = err_count;
	endtask

	task automatic finish_test();
		if (err_count == err_at_start) begin
			pass_count++;
			$display("test %s: passed", test_name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", test_name, err_count - err_at_start);
		end
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		logic [31:0] rnd;
		seed = 32'he100;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		imp_armed = 1'b0;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		test_name = "reset";
		wait_reset_release();

		start_test("reset_valid");
		apply_inputs(1'b1, 1'b1, '0);
		wait_valid_level(1'b1, 60);
		finish_test();

		start_test("impulse");
		repeat (40) apply_inputs(1'b1, 1'b1, '0);
		apply_inputs(1'b1, 1'b1, sample_t'(1));
		imp_armed <= 1'b1;
		apply_inputs(1'b1, 1'b1, '0);
		imp_armed <= 1'b0;
		wait_impulse_done();
		finish_test();

		start_test("random_stream");
		repeat (300) apply_inputs(1'b1, 1'b1, sample_t'($random(seed)));
		finish_test();

		start_test("stalls");
		for (int i = 0; i < 300; i++) begin
			rnd = $random(seed);
			apply_inputs(rnd[1:0] != 2'b00, 1'b1, sample_t'($random(seed)));
		end
		finish_test();

		start_test("valid_gaps");
		for (int i = 0; i < 300; i++) begin
			rnd = $random(seed);
			apply_inputs(rnd[2:0] != 3'b000, rnd[3], sample_t'($random(seed)));
		end
		// flush the last marked samples out
		repeat (DEPTH + 4) apply_inputs(1'b1, 1'b0, '0);
		wait_valid_level(1'b0, 60);
		finish_test();

		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fir.f
+incdir+hdl
hdl/fir_pkg.sv
hdl/fir_tap_delay_line.sv
hdl/fir_fold_multiply.sv
hdl/fir_adder_tree.sv
hdl/fir_valid_delay.sv
hdl/fir_top.sv
testbench/fir_tb_clock.sv
testbench/fir_tb.sv

//--- Bender.yml
package:
  name: fir

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fir_pkg.sv
      - hdl/fir_tap_delay_line.sv
      - hdl/fir_fold_multiply.sv
      - hdl/fir_adder_tree.sv
      - hdl/fir_valid_delay.sv
      - hdl/fir_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/fir_tb_clock.sv
      - testbench/fir_tb.sv
